/* list.f */
+incdir+test
design/tg_defs_pkg.sv
design/tg_single_rw_stage.sv
design/tg_addr_gen.sv
design/tg_cmd_issue.sv
design/tg_read_compare.sv
design/tg_top.sv
test/tg_tb.sv

/* Bender.yml */
package:
  name: tg_traffic_gen

sources:
  - design/tg_defs_pkg.sv
  - design/tg_single_rw_stage.sv
  - design/tg_addr_gen.sv
  - design/tg_cmd_issue.sv
  - design/tg_read_compare.sv
  - design/tg_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tg_tb.sv

/* test/tg_tb_tests.svh */
/*
 * Directed tests for the traffic generator
 * Each one resets the DUT, runs stages and checks the traffic
 */
`default_nettype none

// Plain stage with fixed credit return
task automatic basic_stage_run();
   test_name = "basic_stage";
   reset_dut(1'b0, -1);
   run_stage();
   verify_command_log();
   check_value("stage_complete pulses", 1, complete_count);
   check_value("mismatch", 0, mismatch);
   check_value("error_count", 0, error_count);
   // Reference for the back-pressure run
   basic_log = cmd_log;
endtask

// Random credit delays must give the same commands
task automatic credit_backpressure();
   test_name = "credit_backpressure";
   reset_dut(1'b1, -1);
   run_stage();
   verify_command_log();
   for (int i = 0; i < basic_log.size(); i++)
      check_value($sformatf("command %0d", i), basic_log[i], cmd_log[i]);
   check_value("mismatch", 0, mismatch);
endtask

// Reads drained before the first write of a new generator
task automatic blocking_switch();
   test_name = "blocking_switch";
   reset_dut(1'b1, -1);
   run_stage();
   verify_command_log();
   check_value("reads pending at first RAND write", 0,
               pending_at_write[SEQ_ADDR_COUNT]);
   check_value("reads pending at first RAND_SEQ write", 0,
               pending_at_write[SEQ_ADDR_COUNT + RAND_ADDR_COUNT]);
endtask

task automatic error_detection();
   test_name = "error_detection";
   // Eighth read word comes back with bit 0 flipped
   reset_dut(1'b0, 7);
   run_stage();
   verify_command_log();
   check_value("mismatch", 1, mismatch);
   check_value("error_count", 1, error_count);
endtask

// Two stages without reset in between
task automatic stage_restart();
   test_name = "restart";
   reset_dut(1'b0, -1);
   run_stage();
   verify_command_log();
   // LFSR prediction carries on into the second stage
   run_stage();
   verify_command_log();
   check_value("stage_complete pulses", 2, complete_count);
   check_value("mismatch", 0, mismatch);
endtask

`default_nettype wire

/* test/tg_tb.sv */
/*
 * Memory traffic generator testbench
 * Clock, reset, in-order memory model with delayed credit return,
 * address and data prediction, timeout and the directed test sequence
 */
`timescale 1ns/100ps
`default_nettype none

module tg_tb
   import tg_defs_pkg::*;
();

   localparam int TOTAL_PAIRS  = SEQ_ADDR_COUNT + RAND_ADDR_COUNT + RAND_SEQ_ADDR_COUNT;
   // Six stage runs over all tests with a fixed budget per run
   localparam int STAGE_RUNS     = 6;
   localparam int STAGE_BUDGET   = 600;
   localparam int TIMEOUT_CYCLES = STAGE_RUNS * STAGE_BUDGET + 400;

   logic                  clk;
   logic                  reset_n      = 1'b0;
   logic                  stage_enable = 1'b0;
   logic                  cmd_credit   = 1'b0;
   logic                  rd_valid     = 1'b0;
   logic [DATA_WIDTH-1:0] rd_data      = '0;
   tg_cmd_t               cmd;
   logic                  cmd_valid;
   logic                  stage_complete;
   logic                  mismatch;
   logic [7:0]            error_count;

   // Memory model state
   logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH)-1];
   int                    credit_due_q[$];
   int                    rd_due_q[$];
   logic [DATA_WIDTH-1:0] rd_word_q[$];
   int                    mem_cycle       = 0;
   int                    last_credit_due = 0;
   int                    outstanding     = 0;
   int                    pending_reads   = 0;
   int                    read_count      = 0;
   int                    complete_count  = 0;
   bit                    random_credit   = 1'b0;
   int                    corrupt_read    = -1;
   integer                seed            = 29;

   // Observed and predicted traffic
   tg_cmd_t               cmd_log[$];
   tg_cmd_t               basic_log[$];
   int                    pending_at_write[$];
   logic [ADDR_WIDTH-1:0] exp_addrs[$];
   logic [ADDR_WIDTH-1:0] model_lfsr = LFSR_SEED;

   string                 test_name = "none";
   int                    failures  = 0;
   int                    cycles    = 0;

   tg_top i_tg_top (
      .clk            (clk),
      .reset_n        (reset_n),
      .stage_enable   (stage_enable),
      .cmd_credit     (cmd_credit),
      .rd_valid       (rd_valid),
      .rd_data        (rd_data),
      .cmd            (cmd),
      .cmd_valid      (cmd_valid),
      .stage_complete (stage_complete),
      .mismatch       (mismatch),
      .error_count    (error_count)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////
   // Reporting
   //////////////////////////////
   task automatic stop_on_error(input string line);
      failures++;
      $display("%s", line);
      $display("Finished with errors");
      $fatal(1, "Stopping at first error");
   endtask

   task automatic check_value(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected)
      else
         stop_on_error($sformatf("[ERROR] %s, %s: expected %0h, actual %0h",
                                 test_name, what, expected, actual));
   endtask

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES)
         stop_on_error($sformatf("Timeout: run still busy after %0d cycles in test %s",
                                 cycles, test_name));
   end

   //////////////////////////////
   // Reference rules
   //////////////////////////////
   // Address in the upper half and its inverse in the lower half
   function automatic logic [DATA_WIDTH-1:0] pattern_of(input logic [ADDR_WIDTH-1:0] a);
      return {a, ~a};
   endfunction

   // Left-shifting Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [ADDR_WIDTH-1:0] lfsr_step(input logic [ADDR_WIDTH-1:0] v);
      return {v[14:0], v[15] ^ v[13] ^ v[12] ^ v[10]};
   endfunction

   // Addresses of one stage with the LFSR state carried into the next
   task automatic predict_addresses();
      logic [ADDR_WIDTH-1:0] rs_base;

      rs_base = '0;
      exp_addrs.delete();
      for (int i = 0; i < SEQ_ADDR_COUNT; i++)
         exp_addrs.push_back(ADDR_WIDTH'(i));
      for (int i = 0; i < RAND_ADDR_COUNT; i++)
      begin
         exp_addrs.push_back(model_lfsr);
         model_lfsr = lfsr_step(model_lfsr);
      end
      for (int i = 0; i < RAND_SEQ_ADDR_COUNT; i++)
      begin
         // New base at the start of every run
         if ((i % RAND_SEQ_RUN) == 0)
         begin
            rs_base    = model_lfsr;
            model_lfsr = lfsr_step(model_lfsr);
         end
         exp_addrs.push_back(rs_base + ADDR_WIDTH'(i % RAND_SEQ_RUN));
      end
   endtask

   //////////////////////////////
   // Memory model
   //////////////////////////////
   always @(posedge clk)
   begin : memory_model
      int                    delay;
      int                    due;
      logic [DATA_WIDTH-1:0] word;

      mem_cycle++;
      if (!reset_n)
      begin
         // Forget credits and reads from the previous test
         credit_due_q.delete();
         rd_due_q.delete();
         rd_word_q.delete();
         last_credit_due = 0;
         outstanding     = 0;
         pending_reads   = 0;
         read_count      = 0;
         complete_count  = 0;
         cmd_credit <= 1'b0;
         rd_valid   <= 1'b0;
         rd_data    <= '0;
      end
      else
      begin
         // Pulses the DUT samples at this edge
         if (cmd_credit)
            outstanding--;
         if (rd_valid)
            pending_reads--;
         if (stage_complete)
            complete_count++;

         if (cmd_valid)
         begin
            outstanding++;
            assert (outstanding <= CMD_CREDITS)
            else
               stop_on_error($sformatf(
                  "[ERROR] %s, commands in flight: expected at most %0d, actual %0d",
                  test_name, CMD_CREDITS, outstanding));
            cmd_log.push_back(cmd);
            // Credit back after 2 cycles or a random 2 to 7
            delay = 2;
            if (random_credit)
               delay = 2 + ($unsigned($random(seed)) % 6);
            due = mem_cycle + delay;
            // One credit pulse per cycle at most
            if (due <= last_credit_due)
               due = last_credit_due + 1;
            last_credit_due = due;
            credit_due_q.push_back(due);
            if (cmd.write)
            begin
               mem[cmd.addr] = cmd.wdata;
               pending_at_write.push_back(pending_reads);
            end
            else
            begin
               word = mem[cmd.addr];
               if (read_count == corrupt_read)
                  word[0] = ~word[0];
               read_count++;
               pending_reads++;
               rd_due_q.push_back(mem_cycle + 3);
               rd_word_q.push_back(word);
            end
         end

         if ((credit_due_q.size() != 0) && (credit_due_q[0] <= mem_cycle))
         begin
            cmd_credit <= 1'b1;
            void'(credit_due_q.pop_front());
         end
         else
            cmd_credit <= 1'b0;

         // Read data returns in command order
         if ((rd_due_q.size() != 0) && (rd_due_q[0] <= mem_cycle))
         begin
            rd_valid <= 1'b1;
            rd_data  <= rd_word_q.pop_front();
            void'(rd_due_q.pop_front());
         end
         else
            rd_valid <= 1'b0;
      end
   end

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////
   task automatic reset_dut(input bit randomize_credits, input int corrupt_index);
      @(posedge clk);
      reset_n      <= 1'b0;
      stage_enable <= 1'b0;
      repeat (3) @(posedge clk);
      random_credit = randomize_credits;
      corrupt_read  = corrupt_index;
      model_lfsr    = LFSR_SEED;
      reset_n <= 1'b1;
   endtask

   // Runs one full stage with enable held until the completion pulse
   task automatic run_stage();
      cmd_log.delete();
      pending_at_write.delete();
      predict_addresses();
      @(posedge clk);
      stage_enable <= 1'b1;
      do
         @(posedge clk);
      while (stage_complete !== 1'b1);
      stage_enable <= 1'b0;
      // Let late pulses settle
      repeat (3) @(posedge clk);
   endtask

   // Alternating write/read pairs on the predicted addresses
   task automatic verify_command_log();
      tg_cmd_t wr;
      tg_cmd_t rd;

      check_value("command count", 2 * TOTAL_PAIRS, cmd_log.size());
      for (int p = 0; p < TOTAL_PAIRS; p++)
      begin
         wr = cmd_log[2 * p];
         rd = cmd_log[2 * p + 1];
         check_value($sformatf("pair %0d write flag", p), 1, wr.write);
         check_value($sformatf("pair %0d read flag", p), 0, rd.write);
         check_value($sformatf("pair %0d write address", p), exp_addrs[p], wr.addr);
         check_value($sformatf("pair %0d read address", p), exp_addrs[p], rd.addr);
         check_value($sformatf("pair %0d write data", p), pattern_of(exp_addrs[p]), wr.wdata);
      end
   endtask

   initial
   begin
      basic_stage_run();
      credit_backpressure();
      blocking_switch();
      error_detection();
      stage_restart();
      if (failures == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

   `include "tg_tb_tests.svh"

endmodule

`default_nettype wire

/* design/tg_top.sv */
/*
 * Memory traffic generator top
 * Single write/read stage with address generation, credit-based
 * command issue and read data checking
 */
`timescale 1ns/100ps
`default_nettype none

module tg_top
   import tg_defs_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  stage_enable,

   // Memory side
   input  logic                  cmd_credit,
   input  logic                  rd_valid,
   input  logic [DATA_WIDTH-1:0] rd_data,
   output tg_cmd_t               cmd,
   output logic                  cmd_valid,

   // Status
   output logic                  stage_complete,
   output logic                  mismatch,
   output logic [7:0]            error_count
);

   addr_gen_select_t      addr_gen_select;
   logic                  can_issue;
   logic                  compare_empty;
   logic                  do_write;
   logic                  do_read;
   logic [ADDR_WIDTH-1:0] addr;
   logic                  fifo_full;
   logic                  push;
   logic [ADDR_WIDTH-1:0] push_addr;

   tg_single_rw_stage i_stage (
      .clk             (clk),
      .reset_n         (reset_n),
      .stage_enable    (stage_enable),
      .can_issue       (can_issue),
      .compare_empty   (compare_empty),
      .addr_gen_select (addr_gen_select),
      .do_write        (do_write),
      .do_read         (do_read),
      .stage_complete  (stage_complete)
   );

   // Steps once per pair so write and read share an address
   tg_addr_gen i_addr_gen (
      .clk             (clk),
      .reset_n         (reset_n),
      .addr_gen_select (addr_gen_select),
      .advance         (do_read),
      .restart         (stage_complete),
      .addr            (addr)
   );

   tg_cmd_issue i_cmd_issue (
      .clk        (clk),
      .reset_n    (reset_n),
      .do_write   (do_write),
      .do_read    (do_read),
      .addr       (addr),
      .cmd_credit (cmd_credit),
      .fifo_full  (fifo_full),
      .can_issue  (can_issue),
      .cmd        (cmd),
      .cmd_valid  (cmd_valid),
      .push_addr  (push_addr),
      .push       (push)
   );

   tg_read_compare i_read_compare (
      .clk           (clk),
      .reset_n       (reset_n),
      .push          (push),
      .push_addr     (push_addr),
      .rd_valid      (rd_valid),
      .rd_data       (rd_data),
      .fifo_full     (fifo_full),
      .compare_empty (compare_empty),
      .mismatch      (mismatch),
      .error_count   (error_count)
   );

endmodule

`default_nettype wire

/* design/tg_read_compare.sv */
/*
 * Read compare
 * Queues expected read addresses and checks returned data against the
 * address pattern, keeping a sticky mismatch flag and an error count
 */
`timescale 1ns/100ps
`default_nettype none

module tg_read_compare
   import tg_defs_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  push,
   input  logic [ADDR_WIDTH-1:0] push_addr,
   input  logic                  rd_valid,
   input  logic [DATA_WIDTH-1:0] rd_data,
   output logic                  fifo_full,
   output logic                  compare_empty,
   output logic                  mismatch,
   output logic [7:0]            error_count
);

   localparam int PTR_W = $clog2(CMD_CREDITS);
   localparam int CNT_W = $clog2(CMD_CREDITS + 1);

   logic [ADDR_WIDTH-1:0] exp_mem [CMD_CREDITS];
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [CNT_W-1:0]      count;
   logic [ADDR_WIDTH-1:0] exp_addr;
   logic                  pop;
   logic                  bad_word;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(CMD_CREDITS - 1)) ? '0 : ptr + 1'b1;
   endfunction

   //////////////////////////////
   // Expected-address FIFO
   //////////////////////////////
   always_ff @(posedge clk)
   begin
      if (push)
         exp_mem[wr_ptr] <= push_addr;
   end

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   // An in-flight push already takes a slot
   assign fifo_full = (count == CNT_W'(CMD_CREDITS)) ||
                      (push && (count == CNT_W'(CMD_CREDITS - 1)));

   // Not drained while a read address is still being queued
   assign compare_empty = (count == '0) && !push;

   //////////////////////////////
   // Data check
   //////////////////////////////
   assign exp_addr = exp_mem[rd_ptr];
   assign pop      = rd_valid && (count != '0);

   // A read with nothing expected is also an error
   assign bad_word = rd_valid && ((count == '0) || (rd_data != pattern_data(exp_addr)));

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         mismatch    <= 1'b0;
         error_count <= '0;
      end
      else if (bad_word)
      begin
         mismatch <= 1'b1;
         // Saturates at 255
         if (error_count != 8'hFF)
            error_count <= error_count + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* design/tg_cmd_issue.sv */
/*
 * Command issuer
 * Tracks command credits, registers the outgoing command with its
 * pattern write data and hands read addresses to the comparator
 */
`timescale 1ns/100ps
`default_nettype none

module tg_cmd_issue
   import tg_defs_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  do_write,
   input  logic                  do_read,
   input  logic [ADDR_WIDTH-1:0] addr,
   input  logic                  cmd_credit,
   input  logic                  fifo_full,
   output logic                  can_issue,
   output tg_cmd_t               cmd,
   output logic                  cmd_valid,
   output logic [ADDR_WIDTH-1:0] push_addr,
   output logic                  push
);

   localparam int CREDIT_W = $clog2(CMD_CREDITS + 1);

   logic [CREDIT_W-1:0] credits;
   logic                issue;

   assign issue = do_write | do_read;

   // Needs a credit and room for the expected address
   assign can_issue = (credits != '0) && !fifo_full;

   //////////////////////////////
   // Credit counter
   //////////////////////////////
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
         credits <= CREDIT_W'(CMD_CREDITS);
      else
      begin
         case ({issue, cmd_credit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
         cmd_valid <= 1'b0;
      else
         cmd_valid <= issue;
   end

   // Command payload, reads carry no data
   always_ff @(posedge clk)
   begin
      if (issue)
      begin
         cmd.write <= do_write;
         cmd.addr  <= addr;
         cmd.wdata <= do_write ? pattern_data(addr) : '0;
      end
   end

   // Read address goes to the comparator alongside cmd_valid
   assign push      = cmd_valid && !cmd.write;
   assign push_addr = cmd.addr;

endmodule

`default_nettype wire

/* design/tg_addr_gen.sv */
/*
 * Address generators
 * Sequential counter, 16-bit Fibonacci LFSR and random-sequential runs,
 * selected by the stage and advanced once per write/read pair
 */
`timescale 1ns/100ps
`default_nettype none

module tg_addr_gen
   import tg_defs_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset_n,
   input  addr_gen_select_t      addr_gen_select,
   input  logic                  advance,
   input  logic                  restart,
   output logic [ADDR_WIDTH-1:0] addr
);

   localparam int RUN_W = $clog2(RAND_SEQ_RUN);

   logic [ADDR_WIDTH-1:0] seq_addr;
   logic [ADDR_WIDTH-1:0] lfsr;
   logic [ADDR_WIDTH-1:0] lfsr_next;
   logic [ADDR_WIDTH-1:0] rs_addr;
   logic [RUN_W-1:0]      rs_count;

   // Taps 16, 14, 13, 11
   assign lfsr_next = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         seq_addr <= '0;
         lfsr     <= LFSR_SEED;
         rs_addr  <= '0;
         rs_count <= '0;
      end
      else if (restart)
      begin
         // LFSR keeps running across stages
         seq_addr <= '0;
         rs_count <= '0;
      end
      else if (advance)
      begin
         case (addr_gen_select)
            SEQ:
               seq_addr <= seq_addr + 1'b1;
            RAND:
               lfsr <= lfsr_next;
            RAND_SEQ:
            begin
               // Start of a run uses the LFSR value as base
               if (rs_count == '0)
               begin
                  rs_addr <= lfsr + 1'b1;
                  lfsr    <= lfsr_next;
               end
               else
                  rs_addr <= rs_addr + 1'b1;
               if (rs_count == RUN_W'(RAND_SEQ_RUN - 1))
                  rs_count <= '0;
               else
                  rs_count <= rs_count + 1'b1;
            end
            default:
               ;
         endcase
      end
   end

   // Output mux, base shown directly at run start
   always_comb
   begin
      case (addr_gen_select)
         SEQ:      addr = seq_addr;
         RAND:     addr = lfsr;
         RAND_SEQ: addr = (rs_count == '0) ? lfsr : rs_addr;
         default:  addr = seq_addr;
      endcase
   end

endmodule

`default_nettype wire

/* design/tg_single_rw_stage.sv */
/*
 * Single write/read stage
 * Issues interleaved write and read requests to one address at a time,
 * steps through the sequential, random and random-sequential generators
 * and optionally drains outstanding reads at each generator change
 */
`timescale 1ns/100ps
`default_nettype none

module tg_single_rw_stage
   import tg_defs_pkg::*;
(
   input  logic             clk,
   input  logic             reset_n,
   input  logic             stage_enable,

   // Issue permission and read drain status
   input  logic             can_issue,
   input  logic             compare_empty,

   output addr_gen_select_t addr_gen_select,

   // Request strobes toward the issuer
   output logic             do_write,
   output logic             do_read,

   output logic             stage_complete
);

   localparam int TOTAL_PAIRS  = SEQ_ADDR_COUNT + RAND_ADDR_COUNT + RAND_SEQ_ADDR_COUNT;
   localparam int PAIR_COUNT_W = $clog2(TOTAL_PAIRS + 1);

   typedef enum logic [2:0] {
      IDLE,
      WRITE,
      READ,
      WAIT_GEN,
      WAIT_END,
      DONE
   } state_t;

   state_t                  state;
   logic [PAIR_COUNT_W-1:0] pair_count;
   logic [PAIR_COUNT_W-1:0] pair_next;
   addr_gen_select_t        select_next;

   // Generator owning a given pair number
   function automatic addr_gen_select_t select_for(input logic [PAIR_COUNT_W-1:0] count);
      if (count < PAIR_COUNT_W'(SEQ_ADDR_COUNT))
         return SEQ;
      else if (count < PAIR_COUNT_W'(SEQ_ADDR_COUNT + RAND_ADDR_COUNT))
         return RAND;
      else
         return RAND_SEQ;
   endfunction

   assign pair_next   = pair_count + 1'b1;
   assign select_next = select_for(pair_next);

   //////////////////////////////
   // Stage FSM
   //////////////////////////////
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state           <= IDLE;
         pair_count      <= '0;
         addr_gen_select <= select_for('0);
      end
      else
      begin
         case (state)
            IDLE:
               // Hold until enabled
               if (stage_enable)
                  state <= WRITE;

            WRITE:
               if (can_issue)
                  state <= READ;

            READ:
               // Read completes the pair, so the generator may change here
               if (can_issue)
               begin
                  pair_count      <= pair_next;
                  addr_gen_select <= select_next;
                  if (pair_next == PAIR_COUNT_W'(TOTAL_PAIRS))
                     state <= WAIT_END;
                  else if (USE_BLOCKING_ADDR_GEN && (select_next != addr_gen_select))
                     state <= WAIT_GEN;
                  else
                     state <= WRITE;
               end

            WAIT_GEN:
               // All reads of the old generator back
               if (compare_empty)
                  state <= WRITE;

            WAIT_END:
               if (compare_empty)
                  state <= DONE;

            DONE:
            begin
               pair_count      <= '0;
               addr_gen_select <= select_for('0);
               state           <= IDLE;
            end

            default:
               state <= IDLE;
         endcase
      end
   end

   // Strobes last only while the issuer can take them
   assign do_write = (state == WRITE) && can_issue;
   assign do_read  = (state == READ) && can_issue;

   // Single cycle in DONE
   assign stage_complete = (state == DONE);

endmodule

`default_nettype wire

/* design/tg_defs_pkg.sv */
/*
 * Memory traffic generator shared definitions
 * Widths, stage counts, credit count, generator select, command format
 * and the address-to-data pattern used by writes and read checks
 */
`default_nettype none

package tg_defs_pkg;

   // Memory interface widths
   localparam int ADDR_WIDTH = 16;
   localparam int DATA_WIDTH = 32;

   // Write/read pairs per address generator
   localparam int SEQ_ADDR_COUNT      = 6;
   localparam int RAND_ADDR_COUNT     = 6;
   localparam int RAND_SEQ_ADDR_COUNT = 6;

   // Drain all reads before moving to the next generator
   localparam bit USE_BLOCKING_ADDR_GEN = 1'b1;

   // Credits granted at reset, also the expected-address FIFO depth
   localparam int CMD_CREDITS = 4;

   // Consecutive addresses after each random base
   localparam int RAND_SEQ_RUN = 4;

   localparam logic [ADDR_WIDTH-1:0] LFSR_SEED = 16'hACE1;

   typedef enum logic [1:0] {
      SEQ,
      RAND,
      RAND_SEQ
   } addr_gen_select_t;

   // One command toward the memory
   typedef struct packed {
      logic                  write;
      logic [ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] wdata;
   } tg_cmd_t;

   // Upper half carries the address, lower half its inverse
   function automatic logic [DATA_WIDTH-1:0] pattern_data(input logic [ADDR_WIDTH-1:0] addr);
      return {addr, ~addr};
   endfunction

endpackage

`default_nettype wire
